//--- hw/similarity_pkg.sv
/*
 * Similarity stage shared definitions
 * Record layout, field widths, weight addresses, metric FSM states
 * and the cost and IoU types used by the tracker similarity blocks
 */
package similarity_pkg;

	localparam int COORD_W  = 8;                  // Corner coordinate and feature byte
	localparam int REC_W    = 56;                 // One object record
	localparam int PAIR_W   = 2 * REC_W;          // Frame-k record on top, history below
	localparam int WEIGHT_W = 8;
	localparam int IOU_W    = 9;                  // Q8 fraction, 0..256
	localparam int COST_W   = 20;                 // Six 17-bit terms summed

	localparam logic [IOU_W-1:0] IOU_ONE = 9'd256; // 1.0 in Q8

	// Field LSB positions inside one record, top field first
	localparam int X_TL_LSB    = 48;
	localparam int Y_TL_LSB    = 40;
	localparam int X_BR_LSB    = 32;
	localparam int Y_BR_LSB    = 24;
	localparam int COLOR1_LSB  = 16;
	localparam int COLOR2_LSB  = 8;
	localparam int HISTORY_LSB = 0;

	typedef logic [COST_W-1:0] cost_t;
	typedef logic [IOU_W-1:0]  iou_t;

	typedef enum logic [7:0] {
		W_IOU     = 8'd0,
		W_WIDTH   = 8'd1,
		W_HEIGHT  = 8'd2,
		W_COLOR1  = 8'd3,
		W_COLOR2  = 8'd4,
		W_HISTORY = 8'd5
	} weight_addr_e;

	typedef enum logic [1:0] {
		IDLE,
		WAIT_IOU,
		ACCUM,
		DONE
	} metric_state_e;

	// Span between two corners, a negative span clamps to 0
	function automatic logic [COORD_W-1:0] coord_span(input logic [COORD_W-1:0] lo,
		input logic [COORD_W-1:0] hi);
		coord_span = (hi > lo) ? hi - lo : '0;
	endfunction

endpackage

//--- hw/similarity_input.sv
/*
 * Similarity input side
 * Holds the six feature weights, accepts a record pair on en,
 * splits both records into fields and owns the busy level
 */
`timescale 1ns/1ns
module similarity_input import similarity_pkg::*; (
	input  logic               clk,
	input  logic               reset_N,
	input  logic [PAIR_W-1:0]  data_in,
	input  logic               wr,
	input  logic [7:0]         addr,
	input  logic               en,
	input  logic               sum_done,
	output logic               start,
	output logic               busy,
	output logic [COORD_W-1:0] k_x_tl,
	output logic [COORD_W-1:0] k_y_tl,
	output logic [COORD_W-1:0] k_x_br,
	output logic [COORD_W-1:0] k_y_br,
	output logic [COORD_W-1:0] k_color1,
	output logic [COORD_W-1:0] k_color2,
	output logic [COORD_W-1:0] k_history,
	output logic [COORD_W-1:0] h_x_tl,
	output logic [COORD_W-1:0] h_y_tl,
	output logic [COORD_W-1:0] h_x_br,
	output logic [COORD_W-1:0] h_y_br,
	output logic [COORD_W-1:0] h_color1,
	output logic [COORD_W-1:0] h_color2,
	output logic [COORD_W-1:0] h_history,
	output logic [WEIGHT_W-1:0] w_iou,
	output logic [WEIGHT_W-1:0] w_width,
	output logic [WEIGHT_W-1:0] w_height,
	output logic [WEIGHT_W-1:0] w_color1,
	output logic [WEIGHT_W-1:0] w_color2,
	output logic [WEIGHT_W-1:0] w_history
);

	logic              wr_ok;                      // Weight write accepted
	logic              accept;                     // Pair accepted, wr has priority
	logic [PAIR_W-1:0] pair_q;                     // Captured pair, held while busy

	assign wr_ok  = wr && !busy;
	assign accept = en && !wr && !busy;

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			w_iou     <= '0;
			w_width   <= '0;
			w_height  <= '0;
			w_color1  <= '0;
			w_color2  <= '0;
			w_history <= '0;
		end else if (wr_ok) begin
			case (weight_addr_e'(addr))
				W_IOU:     w_iou     <= data_in[WEIGHT_W-1:0];
				W_WIDTH:   w_width   <= data_in[WEIGHT_W-1:0];
				W_HEIGHT:  w_height  <= data_in[WEIGHT_W-1:0];
				W_COLOR1:  w_color1  <= data_in[WEIGHT_W-1:0];
				W_COLOR2:  w_color2  <= data_in[WEIGHT_W-1:0];
				W_HISTORY: w_history <= data_in[WEIGHT_W-1:0];
				default:   ;                              // Unmapped address dropped
			endcase
		end
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			start <= 1'b0;
			busy  <= 1'b0;
		end else begin
			start <= accept;                          // Single cycle launch
			if (accept)
				busy <= 1'b1;
			else if (sum_done)
				busy <= 1'b0;                         // Falls as valid rises
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			pair_q <= data_in;
	end

	// Frame-k record sits in the upper half
	assign k_x_tl    = pair_q[REC_W + X_TL_LSB    +: COORD_W];
	assign k_y_tl    = pair_q[REC_W + Y_TL_LSB    +: COORD_W];
	assign k_x_br    = pair_q[REC_W + X_BR_LSB    +: COORD_W];
	assign k_y_br    = pair_q[REC_W + Y_BR_LSB    +: COORD_W];
	assign k_color1  = pair_q[REC_W + COLOR1_LSB  +: COORD_W];
	assign k_color2  = pair_q[REC_W + COLOR2_LSB  +: COORD_W];
	assign k_history = pair_q[REC_W + HISTORY_LSB +: COORD_W];

	assign h_x_tl    = pair_q[X_TL_LSB    +: COORD_W];
	assign h_y_tl    = pair_q[Y_TL_LSB    +: COORD_W];
	assign h_x_br    = pair_q[X_BR_LSB    +: COORD_W];
	assign h_y_br    = pair_q[Y_BR_LSB    +: COORD_W];
	assign h_color1  = pair_q[COLOR1_LSB  +: COORD_W];
	assign h_color2  = pair_q[COLOR2_LSB  +: COORD_W];
	assign h_history = pair_q[HISTORY_LSB +: COORD_W];

endmodule

//--- hw/iou_calc.sv
/*
 * Intersection over union of two boxes
 * Box areas and overlap in one cycle, then a restoring divider
 * gives floor(inter * 256 / union) one quotient bit per cycle
 */
`timescale 1ns/1ns
module iou_calc import similarity_pkg::*; (
	input  logic               clk,
	input  logic               reset_N,
	input  logic               start,
	input  logic [COORD_W-1:0] k_x_tl,
	input  logic [COORD_W-1:0] k_y_tl,
	input  logic [COORD_W-1:0] k_x_br,
	input  logic [COORD_W-1:0] k_y_br,
	input  logic [COORD_W-1:0] h_x_tl,
	input  logic [COORD_W-1:0] h_y_tl,
	input  logic [COORD_W-1:0] h_x_br,
	input  logic [COORD_W-1:0] h_y_br,
	output iou_t               iou,
	output logic               iou_done
);

	localparam int AREA_W = 2 * COORD_W;

	logic [COORD_W-1:0] k_w, k_h, h_w, h_h;
	logic [COORD_W-1:0] ov_l, ov_r, ov_t, ov_b;    // Overlap rectangle corners
	logic [COORD_W-1:0] ov_w, ov_h;
	logic [AREA_W-1:0]  area_k, area_h, inter;
	logic [AREA_W:0]    union_c;

	logic               running;                   // Divider active
	logic [3:0]         step_cnt;
	logic [AREA_W:0]    union_q;
	logic [AREA_W:0]    rem;                       // Partial remainder, always below union
	logic [COORD_W:0]   dvd_lo;                    // Dividend bits still to shift in
	logic [AREA_W:0]    trial;
	logic               q_bit;
	iou_t               quo;

	assign k_w = coord_span(k_x_tl, k_x_br);
	assign k_h = coord_span(k_y_tl, k_y_br);
	assign h_w = coord_span(h_x_tl, h_x_br);
	assign h_h = coord_span(h_y_tl, h_y_br);

	assign ov_l = (k_x_tl > h_x_tl) ? k_x_tl : h_x_tl;
	assign ov_r = (k_x_br < h_x_br) ? k_x_br : h_x_br;
	assign ov_t = (k_y_tl > h_y_tl) ? k_y_tl : h_y_tl;
	assign ov_b = (k_y_br < h_y_br) ? k_y_br : h_y_br;
	assign ov_w = coord_span(ov_l, ov_r);          // 0 when disjoint in x
	assign ov_h = coord_span(ov_t, ov_b);

	assign area_k  = k_w * k_h;
	assign area_h  = h_w * h_h;
	assign inter   = ov_w * ov_h;
	assign union_c = {1'b0, area_k} + {1'b0, area_h} - {1'b0, inter};

	// Next remainder bit shifted in, subtract when it fits
	assign trial = {rem[AREA_W-1:0], dvd_lo[COORD_W]};
	assign q_bit = (union_q != '0) && (trial >= union_q); // Zero union yields 0
	assign iou   = quo;

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			running  <= 1'b0;
			step_cnt <= '0;
			iou_done <= 1'b0;
		end else begin
			iou_done <= 1'b0;
			if (start) begin
				running  <= 1'b1;
				step_cnt <= '0;
			end else if (running) begin
				step_cnt <= step_cnt + 4'd1;
				if (step_cnt == 4'(IOU_W - 1)) begin
					running  <= 1'b0;
					iou_done <= 1'b1;             // Quotient complete this edge
				end
			end
		end
	end

	// Dividend is inter << 8, top part inter >> 1 is already below union
	always_ff @(posedge clk) begin
		if (start) begin
			union_q <= union_c;
			rem     <= {2'b00, inter[AREA_W-1:1]};
			dvd_lo  <= {inter[0], {COORD_W{1'b0}}};
		end else if (running) begin
			rem    <= q_bit ? trial - union_q : trial;
			dvd_lo <= {dvd_lo[COORD_W-1:0], 1'b0};
			quo    <= {quo[IOU_W-2:0], q_bit};
		end
	end

endmodule

//--- hw/similarity_metric.sv
/*
 * Weighted similarity cost
 * Waits for the IoU, then adds one weighted feature term per cycle
 * through a single multiplier, six terms in all
 */
`timescale 1ns/1ns
module similarity_metric import similarity_pkg::*; (
	input  logic                clk,
	input  logic                reset_N,
	input  logic                iou_done,
	input  iou_t                iou,
	input  logic [WEIGHT_W-1:0] w_iou,
	input  logic [WEIGHT_W-1:0] w_width,
	input  logic [WEIGHT_W-1:0] w_height,
	input  logic [WEIGHT_W-1:0] w_color1,
	input  logic [WEIGHT_W-1:0] w_color2,
	input  logic [WEIGHT_W-1:0] w_history,
	input  logic [COORD_W-1:0]  k_x_tl,
	input  logic [COORD_W-1:0]  k_y_tl,
	input  logic [COORD_W-1:0]  k_x_br,
	input  logic [COORD_W-1:0]  k_y_br,
	input  logic [COORD_W-1:0]  h_x_tl,
	input  logic [COORD_W-1:0]  h_y_tl,
	input  logic [COORD_W-1:0]  h_x_br,
	input  logic [COORD_W-1:0]  h_y_br,
	input  logic [COORD_W-1:0]  k_color1,
	input  logic [COORD_W-1:0]  k_color2,
	input  logic [COORD_W-1:0]  k_history,
	input  logic [COORD_W-1:0]  h_color1,
	input  logic [COORD_W-1:0]  h_color2,
	input  logic [COORD_W-1:0]  h_history,
	output cost_t               sum_cost,
	output logic                sum_done
);

	localparam logic [2:0] LAST_TERM = 3'd5;     // Six terms, 0..5

	function automatic logic [COORD_W-1:0] abs_diff(input logic [COORD_W-1:0] a,
		input logic [COORD_W-1:0] b);
		abs_diff = (a > b) ? a - b : b - a;
	endfunction

	metric_state_e current_state, next_state;
	logic [2:0]                 term_cnt;
	logic [COORD_W-1:0]         k_w, k_h, h_w, h_h;
	logic [WEIGHT_W-1:0]        term_w;          // Weight of the selected term
	logic [IOU_W-1:0]           term_diff;       // Feature distance of that term
	logic [WEIGHT_W+IOU_W-1:0]  term;
	cost_t                      acc;

	assign k_w = coord_span(k_x_tl, k_x_br);
	assign k_h = coord_span(k_y_tl, k_y_br);
	assign h_w = coord_span(h_x_tl, h_x_br);
	assign h_h = coord_span(h_y_tl, h_y_br);

	always_comb begin
		case (term_cnt)
			3'd0: begin
				term_w    = w_iou;
				term_diff = IOU_ONE - iou;               // Full overlap costs nothing
			end
			3'd1: begin
				term_w    = w_width;
				term_diff = {1'b0, abs_diff(k_w, h_w)};
			end
			3'd2: begin
				term_w    = w_height;
				term_diff = {1'b0, abs_diff(k_h, h_h)};
			end
			3'd3: begin
				term_w    = w_color1;
				term_diff = {1'b0, abs_diff(k_color1, h_color1)};
			end
			3'd4: begin
				term_w    = w_color2;
				term_diff = {1'b0, abs_diff(k_color2, h_color2)};
			end
			default: begin
				term_w    = w_history;
				term_diff = {1'b0, abs_diff(k_history, h_history)};
			end
		endcase
	end

	assign term = term_w * term_diff;

	always_comb begin
		next_state = current_state;
		case (current_state)
			IDLE:     next_state = WAIT_IOU;
			WAIT_IOU: if (iou_done) next_state = ACCUM;   // Term 0 taken on this edge
			ACCUM:    if (term_cnt == LAST_TERM) next_state = DONE;
			DONE:     next_state = IDLE;
			default:  next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			current_state <= IDLE;
			term_cnt      <= '0;
			acc           <= '0;
		end else begin
			current_state <= next_state;
			case (current_state)
				WAIT_IOU: if (iou_done) begin
					acc      <= cost_t'(term);      // Fresh sum per pair
					term_cnt <= 3'd1;
				end
				ACCUM: begin
					acc      <= acc + cost_t'(term);
					term_cnt <= term_cnt + 3'd1;
				end
				default: term_cnt <= '0;
			endcase
		end
	end

	assign sum_done = (current_state == DONE);
	assign sum_cost = acc;

endmodule

//--- hw/similarity_output.sv
/*
 * Similarity output side
 * Registers the pair cost with a valid pulse and keeps the lowest
 * cost of the frame with its pair index
 */
`timescale 1ns/1ns
module similarity_output import similarity_pkg::*; #(
	parameter int IDX_W = 8
) (
	input  logic             clk,
	input  logic             reset_N,
	input  logic             sum_done,
	input  cost_t            sum_cost,
	input  logic             new_frame,
	output logic             valid,
	output cost_t            cost,
	output cost_t            best_cost,
	output logic [IDX_W-1:0] best_index
);

	logic [IDX_W-1:0] pair_idx;                  // Index of the next pair in frame
	cost_t            base_cost;                 // Best so far, restarted on new_frame
	logic [IDX_W-1:0] base_idx;

	assign base_cost = new_frame ? '1 : best_cost;
	assign base_idx  = new_frame ? '0 : pair_idx;

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			valid      <= 1'b0;
			cost       <= '0;
			best_cost  <= '1;
			best_index <= '0;
			pair_idx   <= '0;
		end else begin
			valid <= sum_done;
			if (sum_done) begin
				cost     <= sum_cost;
				pair_idx <= base_idx + 1'b1;
				// Any cost is below the all-ones restart value
				if (sum_cost < base_cost) begin   // Strict, a tie keeps the earlier pair
					best_cost  <= sum_cost;
					best_index <= base_idx;
				end
			end else if (new_frame) begin
				best_cost  <= '1;
				best_index <= '0;
				pair_idx   <= '0;
			end
		end
	end

endmodule

//--- hw/oflow_similarity_top.sv
/*
 * Optical-flow tracker similarity stage
 * Input capture, IoU divider, weighted cost FSM and best-match output
 */
`timescale 1ns/1ns
module oflow_similarity_top import similarity_pkg::*; #(
	parameter int IDX_W = 8                      // Pair index width within a frame
) (
	input  logic              clk,
	input  logic              reset_N,
	input  logic [PAIR_W-1:0] data_in,
	input  logic              wr,
	input  logic [7:0]        addr,
	input  logic              en,
	input  logic              new_frame,
	output logic              busy,
	output logic              valid,
	output cost_t             cost,
	output iou_t              iou,
	output cost_t             best_cost,
	output logic [IDX_W-1:0]  best_index
);

	logic                start, iou_done, sum_done;
	cost_t               sum_cost;
	logic [COORD_W-1:0]  k_x_tl, k_y_tl, k_x_br, k_y_br;
	logic [COORD_W-1:0]  k_color1, k_color2, k_history;
	logic [COORD_W-1:0]  h_x_tl, h_y_tl, h_x_br, h_y_br;
	logic [COORD_W-1:0]  h_color1, h_color2, h_history;
	logic [WEIGHT_W-1:0] w_iou, w_width, w_height, w_color1, w_color2, w_history;

	similarity_input similarity_input_inst (
		.clk, .reset_N, .data_in, .wr, .addr, .en, .sum_done,
		.start, .busy,
		.k_x_tl, .k_y_tl, .k_x_br, .k_y_br, .k_color1, .k_color2, .k_history,
		.h_x_tl, .h_y_tl, .h_x_br, .h_y_br, .h_color1, .h_color2, .h_history,
		.w_iou, .w_width, .w_height, .w_color1, .w_color2, .w_history
	);

	iou_calc iou_calc_inst (
		.clk, .reset_N, .start,
		.k_x_tl, .k_y_tl, .k_x_br, .k_y_br,
		.h_x_tl, .h_y_tl, .h_x_br, .h_y_br,
		.iou, .iou_done
	);

	similarity_metric similarity_metric_inst (
		.clk, .reset_N, .iou_done, .iou,
		.w_iou, .w_width, .w_height, .w_color1, .w_color2, .w_history,
		.k_x_tl, .k_y_tl, .k_x_br, .k_y_br,
		.h_x_tl, .h_y_tl, .h_x_br, .h_y_br,
		.k_color1, .k_color2, .k_history,
		.h_color1, .h_color2, .h_history,
		.sum_cost, .sum_done
	);

	similarity_output #(
		.IDX_W(IDX_W)
	) similarity_output_inst (
		.clk, .reset_N, .sum_done, .sum_cost, .new_frame,
		.valid, .cost, .best_cost, .best_index
	);

endmodule

//--- testbench/similarity_properties.sv
/*
 * Timing checks for the similarity stage
 * Valid pulse width, en to valid bound, busy after reset, start from idle
 */
`timescale 1ns/1ns
module similarity_properties (
	input logic clk,
	input logic reset_N,
	input logic en,
	input logic wr,
	input logic busy,
	input logic start,
	input logic valid
);

	logic       pending;                         // Accepted pair not answered yet
	logic [4:0] wait_cnt;                        // Cycles since the accepted en

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			pending  <= 1'b0;
			wait_cnt <= '0;
		end else if (en && !wr && !busy) begin
			pending  <= 1'b1;
			wait_cnt <= '0;
		end else if (valid)
			pending <= 1'b0;
		else if (pending)
			wait_cnt <= wait_cnt + 5'd1;
	end

	assert property (@(posedge clk) disable iff (!reset_N) valid |=> !valid)
		else $error("valid held longer than one cycle");
	assert property (@(posedge clk) disable iff (!reset_N) pending |-> wait_cnt < 5'd20)
		else $error("valid later than 20 cycles after en");
	assert property (@(posedge clk) $rose(reset_N) |-> !busy)
		else $error("busy high after reset");
	// A new launch only once the previous pair has produced its valid
	assert property (@(posedge clk) disable iff (!reset_N) start |-> !$past(pending && !valid))
		else $error("start fired while a pair was in flight");

endmodule

bind oflow_similarity_top similarity_properties similarity_properties_inst (
	.clk(clk), .reset_N(reset_N), .en(en), .wr(wr),
	.busy(busy), .start(start), .valid(valid)
);

//--- testbench/tb_similarity.sv
/*
 * Testbench for the optical-flow similarity stage
 * Programs weights, sends directed and LCG record pairs, checks cost,
 * IoU and the per-frame best match against a reference model
 */
`timescale 1ns/1ns
module tb_similarity import similarity_pkg::*; ();

	localparam int CLK_PERIOD = 10;
	localparam int N_PAIRS    = 214;             // Directed plus random pairs

	logic               clk;
	logic               reset_N;
	logic [PAIR_W-1:0]  data_in;
	logic               wr;
	logic [7:0]         addr;
	logic               en;
	logic               new_frame;
	logic               busy;
	logic               valid;
	cost_t              cost;
	iou_t               iou;
	cost_t              best_cost;
	logic [7:0]         best_index;

	int                 wt[6];                   // Weights as the DUT should hold them
	logic [31:0]        lcg_state = 32'd3988;
	cost_t              ref_best;
	logic [7:0]         ref_best_idx;
	logic [7:0]         ref_pair_idx;            // Next pair index in frame
	cost_t              exp_cost_q[$];
	iou_t               exp_iou_q[$];
	cost_t              exp_best_q[$];
	logic [7:0]         exp_idx_q[$];

	oflow_similarity_top #(
		.IDX_W(8)
	) oflow_similarity_top_inst (
		.clk, .reset_N, .data_in, .wr, .addr, .en, .new_frame,
		.busy, .valid, .cost, .iou, .best_cost, .best_index
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_cost(input string name, input cost_t got, input cost_t exp);
		if (got !== exp)
			stop_on_error($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_iou(input string name, input iou_t got, input iou_t exp);
		if (got !== exp)
			stop_on_error($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_index(input string name, input logic [7:0] got,
		input logic [7:0] exp);
		if (got !== exp)
			stop_on_error($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_on_error($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Byte n of a record, counted from the top field
	function automatic int field(input logic [REC_W-1:0] rec, input int n);
		return int'(rec[REC_W - 1 - 8 * n -: 8]);
	endfunction

	function automatic int clamped_span(input int lo, input int hi);
		return (hi > lo) ? hi - lo : 0;
	endfunction

	function automatic int distance(input int a, input int b);
		return (a > b) ? a - b : b - a;
	endfunction

	function automatic int box_w(input logic [REC_W-1:0] rec);
		return clamped_span(field(rec, 0), field(rec, 2));
	endfunction

	function automatic int box_h(input logic [REC_W-1:0] rec);
		return clamped_span(field(rec, 1), field(rec, 3));
	endfunction

	function automatic iou_t ref_iou(input logic [PAIR_W-1:0] pair);
		logic [REC_W-1:0] k;
		logic [REC_W-1:0] h;
		int               ow, oh, inter, uni;
		k     = pair[PAIR_W-1:REC_W];
		h     = pair[REC_W-1:0];
		ow    = clamped_span((field(k, 0) > field(h, 0)) ? field(k, 0) : field(h, 0),
			(field(k, 2) < field(h, 2)) ? field(k, 2) : field(h, 2));
		oh    = clamped_span((field(k, 1) > field(h, 1)) ? field(k, 1) : field(h, 1),
			(field(k, 3) < field(h, 3)) ? field(k, 3) : field(h, 3));
		inter = ow * oh;
		uni   = box_w(k) * box_h(k) + box_w(h) * box_h(h) - inter;
		if (uni == 0)
			return '0;                                // Two empty boxes
		return iou_t'((inter * 256) / uni);
	endfunction

	function automatic cost_t ref_cost(input logic [PAIR_W-1:0] pair);
		logic [REC_W-1:0] k;
		logic [REC_W-1:0] h;
		int               total;
		k     = pair[PAIR_W-1:REC_W];
		h     = pair[REC_W-1:0];
		total = wt[0] * (256 - int'(ref_iou(pair)));
		total += wt[1] * distance(box_w(k), box_w(h));
		total += wt[2] * distance(box_h(k), box_h(h));
		for (int i = 4; i < 7; i++)
			total += wt[i - 1] * distance(field(k, i), field(h, i)); // Colours, history
		return cost_t'(total);
	endfunction

	function automatic logic [REC_W-1:0] make_record(input int xt, input int yt,
		input int xb, input int yb, input int c1, input int c2, input int hist);
		return {8'(xt), 8'(yt), 8'(xb), 8'(yb), 8'(c1), 8'(c2), 8'(hist)};
	endfunction

	// Boxes in the lower half so that random pairs overlap often
	function automatic logic [REC_W-1:0] rand_record();
		logic [31:0] r0;
		logic [31:0] r1;
		r0 = lcg_next();
		r1 = lcg_next();
		return make_record(r0[30:24], r0[22:16], r0[30:24] + r0[14:8], r0[22:16] + r0[6:0],
			r1[31:24], r1[23:16], r1[15:8]);
	endfunction

	task automatic write_weight(input int a, input int v);
		@(posedge clk);
		#1;
		wr      = 1'b1;
		addr    = 8'(a);
		data_in = PAIR_W'(v);
		@(posedge clk);
		#1;
		wr = 1'b0;
		if (a < 6)
			wt[a] = v;                               // Other addresses are dropped
	endtask

	task automatic start_frame();
		@(posedge clk);
		#1;
		new_frame = 1'b1;
		@(posedge clk);
		#1;
		new_frame    = 1'b0;
		ref_best     = '1;
		ref_best_idx = '0;
		ref_pair_idx = '0;
	endtask

	task automatic wait_valid();
		do
			@(negedge clk);
		while (valid !== 1'b1);
	endtask

	// poke strobes en and wr while the pair is in flight
	task automatic send_pair(input logic [PAIR_W-1:0] pair, input bit poke);
		cost_t c;
		c = ref_cost(pair);
		if (c < ref_best) begin                      // Strict, ties keep the earlier pair
			ref_best     = c;
			ref_best_idx = ref_pair_idx;
		end
		ref_pair_idx = ref_pair_idx + 8'd1;
		exp_cost_q.push_back(c);
		exp_iou_q.push_back(ref_iou(pair));
		exp_best_q.push_back(ref_best);
		exp_idx_q.push_back(ref_best_idx);
		@(posedge clk);
		#1;
		data_in = pair;
		en      = 1'b1;
		@(posedge clk);
		#1;
		en = 1'b0;
		check_flag("busy", busy, 1'b1);              // Pair taken on that edge
		if (poke) begin
			repeat (3) @(posedge clk);
			#1;
			en      = 1'b1;
			data_in = ~pair;
			@(posedge clk);
			#1;
			en      = 1'b0;
			wr      = 1'b1;
			addr    = 8'(W_WIDTH);
			data_in = PAIR_W'(8'hee);
			@(posedge clk);
			#1;
			wr = 1'b0;
		end
		wait_valid();
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk) begin
		if (reset_N && valid) begin
			if (exp_cost_q.size() == 0)
				stop_on_error("valid pulsed while no pair was in flight");
			else begin
				check_cost("cost", cost, exp_cost_q.pop_front());
				check_iou("iou", iou, exp_iou_q.pop_front());
				check_cost("best_cost", best_cost, exp_best_q.pop_front());
				check_index("best_index", best_index, exp_idx_q.pop_front());
				check_flag("busy", busy, 1'b0);      // Drops as valid rises
			end
		end
	end

	initial begin
		#(CLK_PERIOD * (N_PAIRS * 30 + 300));
		stop_on_error("timeout, valid never arrived for a pair in flight");
	end

	initial begin
		cost_t             first_cost;
		logic [PAIR_W-1:0] pair_a;
		logic [PAIR_W-1:0] pair_b;
		logic [PAIR_W-1:0] pair_same;
		reset_N   = 1'b0;
		data_in   = '0;
		wr        = 1'b0;
		addr      = '0;
		en        = 1'b0;
		new_frame = 1'b0;
		pair_a    = {make_record(10, 20, 60, 80, 100, 50, 7),
			make_record(15, 25, 70, 75, 90, 60, 3)};
		pair_b    = {make_record(40, 40, 90, 70, 10, 20, 30),
			make_record(50, 30, 95, 80, 25, 5, 35)};
		pair_same = {2{make_record(30, 30, 90, 90, 40, 40, 40)}};
		repeat (10) @(posedge clk);
		#1;
		reset_N = 1'b1;
		check_flag("busy", busy, 1'b0);
		check_flag("valid", valid, 1'b0);
		check_cost("best_cost", best_cost, '1);
		check_index("best_index", best_index, '0);
		write_weight(W_IOU, 3);
		write_weight(W_WIDTH, 5);
		write_weight(W_HEIGHT, 4);
		write_weight(W_COLOR1, 2);
		write_weight(W_COLOR2, 1);
		write_weight(W_HISTORY, 6);
		write_weight(6, 200);                      // Unmapped address
		start_frame();

		send_pair(pair_a, 0);
		first_cost = cost;
		write_weight(W_COLOR1, 9);                 // Colour 1 differs by 10
		send_pair(pair_a, 0);
		check_cost("cost change", cost - first_cost, cost_t'(7 * 10));

		send_pair(pair_same, 0);
		check_iou("identical iou", iou, 9'd256);
		check_cost("identical cost", cost, '0);
		send_pair({make_record(0, 0, 20, 20, 1, 2, 3),
			make_record(100, 100, 150, 150, 1, 2, 3)}, 0);
		check_iou("disjoint iou", iou, '0);
		// Inverted corners, both areas clamp to 0
		send_pair({make_record(50, 80, 50, 20, 9, 9, 9), make_record(70, 50, 40, 80, 9, 9, 9)}, 0);
		check_iou("zero-area iou", iou, '0);
		send_pair({make_record(0, 0, 10, 10, 0, 0, 0),
			make_record(5, 5, 15, 15, 0, 0, 0)}, 0);
		check_iou("overlap iou", iou, 9'd36);
		send_pair({make_record(0, 0, 3, 1, 0, 0, 0), make_record(0, 0, 1, 1, 0, 0, 0)}, 0);
		check_iou("nested iou", iou, 9'd85);

		start_frame();
		send_pair(pair_b, 0);
		send_pair(pair_b, 0);                      // Tie keeps index 0
		send_pair(pair_same, 0);
		send_pair(pair_b, 0);
		start_frame();
		send_pair(pair_b, 0);
		send_pair(pair_b, 1);                      // Strobes while busy
		send_pair(pair_a, 0);

		start_frame();
		repeat (200) send_pair({rand_record(), rand_record()}, 0);

		repeat (40) @(posedge clk);                // Room for a stray valid
		if (exp_cost_q.size() != 0)
			stop_on_error("results were left unchecked at the end of the run");
		else begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

//--- build.f
hw/similarity_pkg.sv
hw/similarity_input.sv
hw/iou_calc.sv
hw/similarity_metric.sv
hw/similarity_output.sv
hw/oflow_similarity_top.sv
testbench/similarity_properties.sv
testbench/tb_similarity.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the similarity testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f build.f \
	--top-module tb_similarity -o sim_tb &&
./obj_dir/sim_tb || { echo "simulation did not pass"; exit 1; }
